// File: keyed_fp_adder.f
+incdir+dv
verilog/fp_adder_pkg.sv
verilog/operand_entry.sv
verilog/fp_align.sv
verilog/fp_sum.sv
verilog/fp_normalize.sv
verilog/hex_display.sv
verilog/keyed_fp_adder.sv
dv/keyed_fp_adder_tb.sv

// File: dv/keyed_fp_adder_tasks.svh
`ifndef KEYED_FP_ADDER_TASKS_SVH
`define KEYED_FP_ADDER_TASKS_SVH

	// --------------------------------------------------
	// drive helpers
	// --------------------------------------------------
	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#0.5;
	endtask

	task automatic switch_mode(input mode_t m);
		mode = m;
		next_cycle();    // mode_q follows here
	endtask

	// high nibble first with one strobe per cycle
	task automatic key_in_word(input half_word_t w);
		for (int i = 3; i >= 0; i--) begin
			digit_valid = 1'b1;
			digit       = w[i*4 +: 4];
			next_cycle();
		end
		digit_valid = 1'b0;
	endtask

	task automatic load_operands(input half_word_t a, input half_word_t b);
		switch_mode(MODE_ENTER_A);
		key_in_word(a);
		next_cycle();    // operand_a copies the word
		switch_mode(MODE_ENTER_B);
		key_in_word(b);
		next_cycle();
	endtask

	// --------------------------------------------------
	// reference model of the adder
	// --------------------------------------------------
	task automatic model_add(input half_word_t a, input half_word_t b,
			output half_word_t s, output logic ov, output logic un);
		int   ea, eb, e, ma, mb, va, vb, total, m, n;
		logic sign;
		ea = a[14:10];
		eb = b[14:10];
		ma = (a == 16'h0000) ? 0 : (1024 + a[9:0]) * 4;    // hidden bit and two guard zeros
		mb = (b == 16'h0000) ? 0 : (1024 + b[9:0]) * 4;
		if (ea > eb) begin
			mb   = mb >> (ea - eb);
			e    = ea;
			sign = a[15];
		end else if (eb > ea) begin
			ma   = ma >> (eb - ea);
			e    = eb;
			sign = b[15];
		end else begin
			e    = ea;
			sign = (ma > mb) ? a[15] : b[15];
		end
		va    = a[15] ? -ma : ma;
		vb    = b[15] ? -mb : mb;
		total = va + vb;
		m     = (total < 0) ? -total : total;
		s     = '0;
		ov    = 1'b0;
		un    = 1'b0;
		n     = 0;
		if (m >= 'h2000) begin
			m = m >> 1;
			e = e + 1;
		end
		if (e > EXP_MAX) begin
			s  = {sign, 5'd31, 10'd0};
			ov = 1'b1;
		end else if (m != 0) begin
			while (m < 'h1000) begin
				m = m << 1;
				n++;
			end
			if (e - n < 1) un = 1'b1;    // flush to zero
			else s = {sign, 5'(e - n), 10'(m >> 2)};
		end
	endtask

	// --------------------------------------------------
	// compare tasks
	// --------------------------------------------------
	task automatic check_word(input half_word_t got, input half_word_t want, input string what);
		if (got !== want)
			stop_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, want));
	endtask

	task automatic check_flag(input logic got, input logic want, input string what);
		if (got !== want)
			stop_run($sformatf("Fail at %0t: %s is %b, expected %b", $time, what, got, want));
	endtask

	task automatic check_seg(input seg_t got, input seg_t want, input string what);
		if (got !== want)
			stop_run($sformatf("Fail at %0t: %s is %h, expected %h", $time, what, got, want));
	endtask

	task automatic check_display(input half_word_t w);
		check_seg(hex0, SEG_TABLE[w[3:0]], "hex0");
		check_seg(hex1, SEG_TABLE[w[7:4]], "hex1");
		check_seg(hex2, SEG_TABLE[w[11:8]], "hex2");
		check_seg(hex3, SEG_TABLE[w[15:12]], "hex3");
	endtask

	task automatic check_blank();
		check_seg(hex0, SEG_BLANK, "hex0 blank");
		check_seg(hex1, SEG_BLANK, "hex1 blank");
		check_seg(hex2, SEG_BLANK, "hex2 blank");
		check_seg(hex3, SEG_BLANK, "hex3 blank");
	endtask

	// --------------------------------------------------
	// one addition through the pipeline
	// --------------------------------------------------
	task automatic run_add(input half_word_t a, input half_word_t b);
		half_word_t want_sum;
		logic       want_over, want_under;
		int         cycles;
		model_add(a, b, want_sum, want_over, want_under);
		load_operands(a, b);
		switch_mode(MODE_ADD);    // start pulses on this edge
		cycles = 0;
		while (!result_valid && cycles < 4 * PIPE_LATENCY) begin
			next_cycle();
			cycles++;
		end
		if (!result_valid)
			stop_run("result_valid never came");
		if (cycles != PIPE_LATENCY)
			stop_run($sformatf("Fail at %0t: result after %0d cycles, expected %0d",
				$time, cycles, PIPE_LATENCY));
		check_word(sum, want_sum, $sformatf("sum of %h + %h", a, b));
		check_flag(over, want_over, "over");
		check_flag(under, want_under, "under");
		check_blank();    // nothing shown before the result
		next_cycle();
		check_flag(result_valid, 1'b0, "result_valid one cycle later");
		check_word(sum, want_sum, "held sum");
		check_display(want_sum);
		next_cycle();
		check_flag(over, want_over, "held over");
		check_flag(under, want_under, "held under");
		check_display(want_sum);    // now from the display's own copy
	endtask

	// --------------------------------------------------
	// tests
	// --------------------------------------------------
	task automatic test_reset_idle();
		check_word(sum, 16'h0000, "sum after reset");
		check_flag(over, 1'b0, "over after reset");
		check_flag(under, 1'b0, "under after reset");
		repeat (8) begin
			check_flag(result_valid, 1'b0, "result_valid while idle");
			check_blank();
			next_cycle();
		end
	endtask

	task automatic test_digit_entry();
		switch_mode(MODE_ENTER_A);
		key_in_word(16'h9e2b);
		check_display(16'h09e2);    // last digit not shown yet
		next_cycle();
		check_display(16'h9e2b);
		switch_mode(MODE_CLEAR);
		next_cycle();
		check_blank();
	endtask

	task automatic test_directed_adds();
		run_add(16'h3c00, 16'h3c00);
		check_word(sum, 16'h4000, "1.0 + 1.0");
		run_add(16'h4000, 16'hbc00);
		check_word(sum, 16'h3c00, "2.0 - 1.0");
		run_add(16'h3c00, 16'hbc00);
		check_word(sum, 16'h0000, "exact cancellation");
		run_add(16'h3e00, 16'h4080);
		run_add(16'hc200, 16'h3d00);
		run_add(16'hbd00, 16'h3d00);
		run_add(16'h0000, 16'h4500);
		run_add(16'h5a3c, 16'h1234);    // shifted out entirely
		run_add(16'h4555, 16'hc554);
	endtask

	task automatic test_over_under();
		run_add(16'h7c00, 16'h7c00);
		check_flag(over, 1'b1, "over on large pair");
		check_word(sum, 16'h7c00, "saturated sum");
		run_add(16'hffff, 16'hffff);
		check_flag(over, 1'b1, "over on negative pair");
		check_word(sum, 16'hfc00, "saturated negative sum");
		run_add(16'h0600, 16'h8500);
		check_flag(under, 1'b1, "under on small pair");
		check_word(sum, 16'h0000, "flushed sum");
	endtask

	task automatic test_random_adds();
		logic [31:0] r;
		half_word_t  a, b;
		for (int i = 0; i < 200; i++) begin
			r = next_random();
			a = r[31:16];
			r = next_random();
			b = r[23:8];
			run_add(a, b);
		end
	endtask

`endif

// File: dv/keyed_fp_adder_tb.sv
`timescale 1ns/100ps

module keyed_fp_adder_tb import fp_adder_pkg::*; ();

	logic       clk;
	logic       reset;
	mode_t      mode;
	logic       digit_valid;
	digit_t     digit;
	half_word_t sum;
	logic       result_valid;
	logic       over;
	logic       under;
	seg_t       hex0, hex1, hex2, hex3;

	logic [31:0] lcg_state;    // random word generator state

	keyed_fp_adder dut (
		.clk          (clk),
		.reset        (reset),
		.mode         (mode),
		.digit_valid  (digit_valid),
		.digit        (digit),
		.sum          (sum),
		.result_valid (result_valid),
		.over         (over),
		.under        (under),
		.hex0         (hex0),
		.hex1         (hex1),
		.hex2         (hex2),
		.hex3         (hex3)
	);

	// 4 ns clock
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1);
	endtask

`include "keyed_fp_adder_tasks.svh"

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		lcg_state   = 32'h98b25e03;
		reset       = 1'b1;
		mode        = MODE_CLEAR;
		digit_valid = 1'b0;
		digit       = '0;

		repeat (4) @(posedge clk);
		#0.5;
		reset = 1'b0;

		test_reset_idle();
		test_digit_entry();
		test_directed_adds();
		test_over_under();
		test_random_adds();

		$display("Everything OK");
		$finish;
	end

endmodule

// File: verilog/keyed_fp_adder.sv
`timescale 1ns/100ps

module keyed_fp_adder import fp_adder_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  mode_t      mode,
	input  logic       digit_valid,
	input  digit_t     digit,
	output half_word_t sum,
	output logic       result_valid,
	output logic       over,
	output logic       under,
	output seg_t       hex0,
	output seg_t       hex1,
	output seg_t       hex2,
	output seg_t       hex3
);

	// entry side
	mode_t      mode_q;
	half_word_t entry_word;
	half_word_t operand_a, operand_b;
	logic       start;

	// stage 1 to 2
	wide_t num_a, num_b;
	exp_t  exp_s1;
	logic  sign_s1, valid_s1;

	// stage 3 to 4
	mant_t mag_s3;
	exp_t  exp_s3;
	logic  sign_s3, over_s3, valid_s3;

	operand_entry u_entry (
		.clk         (clk),
		.reset       (reset),
		.mode        (mode),
		.digit_valid (digit_valid),
		.digit       (digit),
		.mode_q      (mode_q),
		.entry_word  (entry_word),
		.operand_a   (operand_a),
		.operand_b   (operand_b),
		.start       (start)
	);

	// --------------------------------------------------
	// five stage adder pipeline
	// --------------------------------------------------
	fp_align u_align (
		.clk       (clk),
		.reset     (reset),
		.start     (start),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.num_a     (num_a),
		.num_b     (num_b),
		.exp_out   (exp_s1),
		.sign_out  (sign_s1),
		.valid_out (valid_s1)
	);

	fp_sum u_sum (
		.clk       (clk),
		.reset     (reset),
		.num_a     (num_a),
		.num_b     (num_b),
		.exp_in    (exp_s1),
		.sign_in   (sign_s1),
		.valid_in  (valid_s1),
		.mag       (mag_s3),
		.exp_out   (exp_s3),
		.sign_out  (sign_s3),
		.over      (over_s3),
		.valid_out (valid_s3)
	);

	fp_normalize u_norm (
		.clk          (clk),
		.reset        (reset),
		.mag          (mag_s3),
		.exp_in       (exp_s3),
		.sign_in      (sign_s3),
		.over_in      (over_s3),
		.valid_in     (valid_s3),
		.sum          (sum),
		.over         (over),
		.under        (under),
		.result_valid (result_valid)
	);

	hex_display u_disp (
		.clk          (clk),
		.reset        (reset),
		.mode_q       (mode_q),
		.entry_word   (entry_word),
		.sum          (sum),
		.result_valid (result_valid),
		.hex0         (hex0),
		.hex1         (hex1),
		.hex2         (hex2),
		.hex3         (hex3)
	);

endmodule

// File: verilog/hex_display.sv
`timescale 1ns/100ps

module hex_display import fp_adder_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  mode_t      mode_q,
	input  half_word_t entry_word,
	input  half_word_t sum,
	input  logic       result_valid,
	output seg_t       hex0,
	output seg_t       hex1,
	output seg_t       hex2,
	output seg_t       hex3
);

	half_word_t held_sum;
	half_word_t show_word;
	logic       have_result;
	logic       show;

	always_ff @(posedge clk) begin
		if (result_valid) held_sum <= sum;
	end

	// cleared outside add mode so each add starts blank
	always_ff @(posedge clk) begin
		if (reset || mode_q != MODE_ADD) have_result <= 1'b0;
		else if (result_valid) have_result <= 1'b1;
	end

	always_comb begin
		show_word = entry_word;
		show      = 1'b1;
		case (mode_q)
			MODE_CLEAR: show = 1'b0;
			MODE_ADD: begin
				show      = have_result || result_valid;
				show_word = result_valid ? sum : held_sum;    // bypass the fresh result
			end
			default: ;
		endcase
	end

	// --------------------------------------------------
	// digit registers, hex0 is the low nibble
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || !show) begin
			hex0 <= SEG_BLANK;
			hex1 <= SEG_BLANK;
			hex2 <= SEG_BLANK;
			hex3 <= SEG_BLANK;
		end else begin
			hex0 <= SEG_TABLE[show_word[3:0]];
			hex1 <= SEG_TABLE[show_word[7:4]];
			hex2 <= SEG_TABLE[show_word[11:8]];
			hex3 <= SEG_TABLE[show_word[15:12]];
		end
	end

endmodule

// File: verilog/fp_normalize.sv
`timescale 1ns/100ps

module fp_normalize import fp_adder_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  mant_t      mag,
	input  exp_t       exp_in,
	input  logic       sign_in,
	input  logic       over_in,
	input  logic       valid_in,
	output half_word_t sum,
	output logic       over,
	output logic       under,
	output logic       result_valid
);

	logic [3:0] lz, lz_q;
	mant_t      mag_q;
	mant_t      shifted;
	exp_t       exp_q;
	logic       sign_q, over_q, valid_q;
	logic       too_small;

	// leading zeros above the first one, 13 for zero
	function automatic logic [3:0] count_lz(mant_t m);
		logic [3:0] n;
		logic       found;
		n     = 4'd0;
		found = 1'b0;
		for (int i = MANT_W-1; i >= 0; i--) begin
			if (m[i]) found = 1'b1;
			else if (!found) n = n + 4'd1;
		end
		return n;
	endfunction

	assign lz = count_lz(mag);

	// stage 4
	always_ff @(posedge clk) begin
		lz_q   <= lz;
		mag_q  <= mag;
		exp_q  <= exp_in;
		sign_q <= sign_in;
		over_q <= over_in;
	end

	assign shifted   = mag_q << lz_q;
	assign too_small = ({1'b0, exp_q} <= {2'b00, lz_q});    // exponent would drop below 1

	// --------------------------------------------------
	// stage 5, shift, flush and pack
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q      <= 1'b0;
			result_valid <= 1'b0;
			sum          <= '0;
			over         <= 1'b0;
			under        <= 1'b0;
		end else begin
			valid_q      <= valid_in;
			result_valid <= valid_q;
			if (valid_q) begin
				over  <= over_q;
				under <= 1'b0;
				if (over_q) begin
					sum <= {sign_q, exp_q, {FRAC_W{1'b0}}};
				end else if (mag_q == '0) begin
					sum <= '0;
				end else if (too_small) begin
					sum   <= '0;
					under <= 1'b1;
				end else begin
					sum <= {sign_q, exp_t'(exp_q - lz_q), shifted[MANT_W-2:GUARD_W]};
				end
			end
		end
	end

endmodule

// File: verilog/fp_sum.sv
`timescale 1ns/100ps

module fp_sum import fp_adder_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  wide_t num_a,
	input  wide_t num_b,
	input  exp_t  exp_in,
	input  logic  sign_in,
	input  logic  valid_in,
	output mant_t mag,
	output exp_t  exp_out,
	output logic  sign_out,
	output logic  over,
	output logic  valid_out
);

	wide_t sum_q;
	wide_t abs_sum;
	exp_t  exp_q;
	logic  sign_q;
	logic  valid_q;

	// --------------------------------------------------
	// stage 2, signed add
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		sum_q  <= num_a + num_b;
		exp_q  <= exp_in;
		sign_q <= sign_in;
	end

	assign abs_sum = sum_q[MANT_W+1] ? -sum_q : sum_q;

	// stage 3, magnitude and carry fix
	always_ff @(posedge clk) begin
		sign_out <= sign_q;
		over     <= 1'b0;
		mag      <= abs_sum[MANT_W-1:0];
		exp_out  <= exp_q;
		if (abs_sum[MANT_W]) begin
			if (exp_q == exp_t'(EXP_MAX)) begin
				mag  <= {1'b1, {(MANT_W-1){1'b0}}};    // saturate, fraction zero
				over <= 1'b1;
			end else begin
				mag     <= abs_sum[MANT_W:1];
				exp_out <= exp_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q   <= 1'b0;
			valid_out <= 1'b0;
		end else begin
			valid_q   <= valid_in;
			valid_out <= valid_q;
		end
	end

endmodule

// File: verilog/fp_align.sv
`timescale 1ns/100ps

module fp_align import fp_adder_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       start,
	input  half_word_t operand_a,
	input  half_word_t operand_b,
	output wide_t      num_a,
	output wide_t      num_b,
	output exp_t       exp_out,
	output logic       sign_out,
	output logic       valid_out
);

	exp_t  exp_a, exp_b, exp_big;
	mant_t mant_a, mant_b;
	mant_t al_a, al_b;
	wide_t ext_a, ext_b;
	logic  sign_big;

	// hidden bit is clear only for the all-zero word
	assign exp_a  = operand_a[FRAC_W +: EXP_W];
	assign exp_b  = operand_b[FRAC_W +: EXP_W];
	assign mant_a = {|operand_a, operand_a[FRAC_W-1:0], {GUARD_W{1'b0}}};
	assign mant_b = {|operand_b, operand_b[FRAC_W-1:0], {GUARD_W{1'b0}}};

	// align to the larger exponent, shifted out bits are lost
	always_comb begin
		al_a     = mant_a;
		al_b     = mant_b;
		exp_big  = exp_a;
		sign_big = operand_a[15];
		if (exp_a > exp_b) begin
			al_b = mant_b >> (exp_a - exp_b);
		end else if (exp_b > exp_a) begin
			al_a     = mant_a >> (exp_b - exp_a);
			exp_big  = exp_b;
			sign_big = operand_b[15];
		end else if (al_a <= al_b) begin
			sign_big = operand_b[15];    // tie goes to b
		end
	end

	assign ext_a = {2'b00, al_a};
	assign ext_b = {2'b00, al_b};

	always_ff @(posedge clk) begin
		num_a    <= operand_a[15] ? -ext_a : ext_a;
		num_b    <= operand_b[15] ? -ext_b : ext_b;
		exp_out  <= exp_big;
		sign_out <= sign_big;
	end

	always_ff @(posedge clk) begin
		if (reset) valid_out <= 1'b0;
		else valid_out <= start;
	end

endmodule

// File: verilog/operand_entry.sv
`timescale 1ns/100ps

module operand_entry import fp_adder_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  mode_t      mode,
	input  logic       digit_valid,
	input  digit_t     digit,
	output mode_t      mode_q,
	output half_word_t entry_word,
	output half_word_t operand_a,
	output half_word_t operand_b,
	output logic       start
);

	logic mode_change;
	logic entering;

	assign mode_change = (mode != mode_q);
	assign entering    = (mode == MODE_ENTER_A) || (mode == MODE_ENTER_B);

	// mode register and start pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			mode_q <= MODE_CLEAR;
			start  <= 1'b0;
		end else begin
			mode_q <= mode;
			start  <= mode_change && (mode == MODE_ADD);    // one cycle only
		end
	end

	// --------------------------------------------------
	// digit shift register
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset || mode == MODE_CLEAR) begin
			entry_word <= '0;
		end else if (entering && mode_change) begin
			entry_word <= '0;    // fresh word on entering a mode
		end else if (entering && digit_valid) begin
			entry_word <= {entry_word[11:0], digit};
		end
	end

	// operands track the word of their own mode
	always_ff @(posedge clk) begin
		if (reset) begin
			operand_a <= '0;
			operand_b <= '0;
		end else begin
			case (mode_q)
				MODE_ENTER_A: operand_a <= entry_word;
				MODE_ENTER_B: operand_b <= entry_word;
				default: ;    // clear and add keep both
			endcase
		end
	end

endmodule

// File: verilog/fp_adder_pkg.sv
package fp_adder_pkg;

	// --------------------------------------------------
	// half precision format
	// --------------------------------------------------
	localparam int EXP_W   = 5;
	localparam int FRAC_W  = 10;
	localparam int GUARD_W = 2;
	localparam int MANT_W  = 13;    // hidden bit + fraction + guard
	localparam int EXP_MAX = 31;

	localparam int PIPE_LATENCY = 5;    // start to result_valid

	typedef logic [15:0]              half_word_t;
	typedef logic [EXP_W-1:0]         exp_t;
	typedef logic [MANT_W-1:0]        mant_t;
	typedef logic signed [MANT_W+1:0] wide_t;
	typedef logic [3:0]               digit_t;
	typedef logic [6:0]               seg_t;

	// host modes, gray ordered as the switch sequence
	typedef enum logic [1:0] {
		MODE_CLEAR   = 2'b00,
		MODE_ENTER_A = 2'b01,
		MODE_ENTER_B = 2'b11,
		MODE_ADD     = 2'b10
	} mode_t;

	// --------------------------------------------------
	// seven segment, active low, bit 0 is segment a
	// --------------------------------------------------
	localparam seg_t SEG_BLANK = 7'h7f;

	localparam seg_t SEG_TABLE [16] = '{
		~7'b0111111,    // 0
		~7'b0000110,    // 1
		~7'b1011011,    // 2
		~7'b1001111,    // 3
		~7'b1100110,    // 4
		~7'b1101101,    // 5
		~7'b1111101,    // 6
		~7'b0000111,    // 7
		~7'b1111111,    // 8
		~7'b1101111,    // 9
		~7'b1110111,    // A
		~7'b1111100,    // b
		~7'b0111001,    // C
		~7'b1011110,    // d
		~7'b1111001,    // E
		~7'b1110001     // F
	};

endpackage
